// ==== source/lsu_pkg.sv ====
package lsu_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int XLEN          = 64;
  localparam int VLEN          = 39;   // sv39 virtual address space
  localparam int PAGE_OFFSET_W = 12;
  localparam int BE_W          = XLEN / 8;
  localparam int BYTE_SEL_W    = $clog2(BE_W);             // byte within dword
  localparam int WORD_ADDR_W   = PAGE_OFFSET_W - BYTE_SEL_W;  // dword within page

  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [BE_W-1:0]          be_t;
  typedef logic [2:0]               trans_id_t;
  typedef logic [PAGE_OFFSET_W-1:0] page_offset_t;
  typedef logic [WORD_ADDR_W-1:0]   word_addr_t;
  typedef logic [3:0]               exc_cause_t;

  // ==============================
  // exception causes
  // ==============================
  localparam exc_cause_t CAUSE_LD_MISALIGNED = 4'd4;
  localparam exc_cause_t CAUSE_ST_MISALIGNED = 4'd6;
  localparam exc_cause_t CAUSE_LD_PAGE_FAULT = 4'd13;
  localparam exc_cause_t CAUSE_ST_PAGE_FAULT = 4'd15;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_B,
    SIZE_H,
    SIZE_W,
    SIZE_D
  } mem_size_t;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_WAIT_GNT,
    LD_WAIT_DATA,
    LD_DONE
  } ld_state_t;

endpackage

// ==== source/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;

  logic                req;
  logic                gnt;    // same cycle as req
  logic                we;
  lsu_pkg::word_addr_t addr;   // dword index
  lsu_pkg::xlen_t      wdata;
  lsu_pkg::be_t        be;
  logic                rvalid; // one cycle after a granted read
  lsu_pkg::xlen_t      rdata;

  modport client (
    output req, we, addr, wdata, be,
    input  gnt, rvalid, rdata
  );

  modport server (
    input  req, we, addr, wdata, be,
    output gnt, rvalid, rdata
  );

endinterface

// ==== source/lsu_ctrl_if.sv ====
`timescale 1ns/1ps

interface lsu_ctrl_if;

  // head of the request queue
  logic                 valid;
  logic                 is_store;
  lsu_pkg::mem_size_t   size;
  logic                 sign_ext;
  lsu_pkg::xlen_t       vaddr;
  lsu_pkg::xlen_t       wdata;    // already in its byte lane
  lsu_pkg::be_t         be;
  lsu_pkg::trans_id_t   trans_id;
  logic                 ex_valid;
  lsu_pkg::exc_cause_t  ex_cause;
  logic                 pop_ld;
  logic                 pop_st;

  modport source  (output valid, is_store, size, sign_ext, vaddr, wdata, be, trans_id,
                   ex_valid, ex_cause, input pop_ld, pop_st);
  modport ld_sink (input valid, is_store, size, sign_ext, vaddr, trans_id, ex_valid,
                   ex_cause, output pop_ld);
  modport st_sink (input valid, is_store, vaddr, wdata, be, trans_id, ex_valid, ex_cause,
                   output pop_st);

endinterface

// ==== source/lsu_addr_check.sv ====
`timescale 1ns/1ps

module lsu_addr_check (
  input  logic                is_store_i,
  input  lsu_pkg::mem_size_t  size_i,
  input  lsu_pkg::xlen_t      operand_a_i,
  input  lsu_pkg::xlen_t      imm_i,
  input  lsu_pkg::xlen_t      store_data_i,
  output lsu_pkg::xlen_t      vaddr_o,
  output lsu_pkg::be_t        be_o,
  output lsu_pkg::xlen_t      wdata_o,
  output logic                ex_valid_o,
  output lsu_pkg::exc_cause_t ex_cause_o
);

  logic         overflow, misaligned;
  lsu_pkg::be_t be_base;

  assign vaddr_o = operand_a_i + imm_i;

  // upper bits must be a sign extension of bit 38
  assign overflow = !((&vaddr_o[lsu_pkg::XLEN-1:lsu_pkg::VLEN-1]) ||
                      !(|vaddr_o[lsu_pkg::XLEN-1:lsu_pkg::VLEN-1]));

  always_comb begin
    misaligned = 1'b0;
    be_base    = 8'h01;
    case (size_i)
      lsu_pkg::SIZE_H: begin
        misaligned = vaddr_o[0];
        be_base    = 8'h03;
      end
      lsu_pkg::SIZE_W: begin
        misaligned = |vaddr_o[1:0];
        be_base    = 8'h0f;
      end
      lsu_pkg::SIZE_D: begin
        misaligned = |vaddr_o[2:0];
        be_base    = 8'hff;
      end
      default: ;  // bytes are always aligned
    endcase
  end

  assign be_o    = be_base << vaddr_o[2:0];
  assign wdata_o = store_data_i << {vaddr_o[2:0], 3'b000};  // into its byte lane

  // page fault beats misalignment
  assign ex_valid_o = overflow || misaligned;
  assign ex_cause_o = overflow ? (is_store_i ? lsu_pkg::CAUSE_ST_PAGE_FAULT
                                             : lsu_pkg::CAUSE_LD_PAGE_FAULT)
                               : (is_store_i ? lsu_pkg::CAUSE_ST_MISALIGNED
                                             : lsu_pkg::CAUSE_LD_MISALIGNED);

endmodule

// ==== source/lsu_bypass.sv ====
`timescale 1ns/1ps

module lsu_bypass #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                valid_i,
  input  logic                is_store_i,
  input  lsu_pkg::mem_size_t  size_i,
  input  logic                sign_ext_i,
  input  lsu_pkg::xlen_t      vaddr_i,
  input  lsu_pkg::xlen_t      wdata_i,
  input  lsu_pkg::be_t        be_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  input  logic                ex_valid_i,
  input  lsu_pkg::exc_cause_t ex_cause_i,
  output logic                ready_o,
  lsu_ctrl_if.source          ctrl
);

  localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CW = $clog2(QUEUE_DEPTH + 1);

  logic                is_store_q [QUEUE_DEPTH];
  lsu_pkg::mem_size_t  size_q     [QUEUE_DEPTH];
  logic                sign_ext_q [QUEUE_DEPTH];
  lsu_pkg::xlen_t      vaddr_q    [QUEUE_DEPTH];
  lsu_pkg::xlen_t      wdata_q    [QUEUE_DEPTH];
  lsu_pkg::be_t        be_q       [QUEUE_DEPTH];
  lsu_pkg::trans_id_t  trans_id_q [QUEUE_DEPTH];
  logic                ex_valid_q [QUEUE_DEPTH];
  lsu_pkg::exc_cause_t ex_cause_q [QUEUE_DEPTH];

  logic [PW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push, pop;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign ready_o = (count_q != CW'(QUEUE_DEPTH));
  assign push    = valid_i && ready_o;
  assign pop     = ctrl.pop_ld || ctrl.pop_st;  // units only pop their own kind

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      is_store_q[wr_ptr_q] <= is_store_i;
      size_q[wr_ptr_q]     <= size_i;
      sign_ext_q[wr_ptr_q] <= sign_ext_i;
      vaddr_q[wr_ptr_q]    <= vaddr_i;
      wdata_q[wr_ptr_q]    <= wdata_i;
      be_q[wr_ptr_q]       <= be_i;
      trans_id_q[wr_ptr_q] <= trans_id_i;
      ex_valid_q[wr_ptr_q] <= ex_valid_i;
      ex_cause_q[wr_ptr_q] <= ex_cause_i;
    end
  end

  assign ctrl.valid    = (count_q != '0);
  assign ctrl.is_store = is_store_q[rd_ptr_q];
  assign ctrl.size     = size_q[rd_ptr_q];
  assign ctrl.sign_ext = sign_ext_q[rd_ptr_q];
  assign ctrl.vaddr    = vaddr_q[rd_ptr_q];
  assign ctrl.wdata    = wdata_q[rd_ptr_q];
  assign ctrl.be       = be_q[rd_ptr_q];
  assign ctrl.trans_id = trans_id_q[rd_ptr_q];
  assign ctrl.ex_valid = ex_valid_q[rd_ptr_q];
  assign ctrl.ex_cause = ex_cause_q[rd_ptr_q];

endmodule

// ==== source/load_unit.sv ====
`timescale 1ns/1ps

module load_unit (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   offset_match_i,
  output lsu_pkg::page_offset_t  ld_page_offset_o,
  output logic                   valid_o,
  output lsu_pkg::trans_id_t     trans_id_o,
  output lsu_pkg::xlen_t         result_o,
  output logic                   exception_o,
  output lsu_pkg::exc_cause_t    cause_o,
  lsu_ctrl_if.ld_sink            ctrl,
  mem_port_if.client             mem
);

  lsu_pkg::ld_state_t  state_q;
  lsu_pkg::xlen_t      vaddr_q, lane, extended;
  lsu_pkg::mem_size_t  size_q;
  logic                sign_ext_q;
  logic                take;

  // head is a load and we are free
  assign take = (state_q == lsu_pkg::LD_IDLE) && ctrl.valid && !ctrl.is_store;

  // excepted loads leave at once, others once the read is granted
  assign ctrl.pop_ld = (take && ctrl.ex_valid) || (mem.req && mem.gnt);

  assign ld_page_offset_o = vaddr_q[lsu_pkg::PAGE_OFFSET_W-1:0];

  assign mem.req   = (state_q == lsu_pkg::LD_WAIT_GNT) && !offset_match_i;  // stall on hazard
  assign mem.we    = 1'b0;
  assign mem.addr  = vaddr_q[lsu_pkg::PAGE_OFFSET_W-1:lsu_pkg::BYTE_SEL_W];
  assign mem.wdata = '0;
  assign mem.be    = '1;

  // ==============================
  // lane select and extension
  // ==============================
  always_comb begin
    lane = mem.rdata >> {vaddr_q[2:0], 3'b000};
    case (size_q)
      lsu_pkg::SIZE_B: extended = {{56{sign_ext_q & lane[7]}}, lane[7:0]};
      lsu_pkg::SIZE_H: extended = {{48{sign_ext_q & lane[15]}}, lane[15:0]};
      lsu_pkg::SIZE_W: extended = {{32{sign_ext_q & lane[31]}}, lane[31:0]};
      default:         extended = lane;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= lsu_pkg::LD_IDLE;
    end else begin
      case (state_q)
        lsu_pkg::LD_IDLE:
          if (take) state_q <= ctrl.ex_valid ? lsu_pkg::LD_DONE : lsu_pkg::LD_WAIT_GNT;
        lsu_pkg::LD_WAIT_GNT:  if (mem.req && mem.gnt) state_q <= lsu_pkg::LD_WAIT_DATA;
        lsu_pkg::LD_WAIT_DATA: if (mem.rvalid) state_q <= lsu_pkg::LD_DONE;
        default:               state_q <= lsu_pkg::LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      vaddr_q     <= ctrl.vaddr;
      size_q      <= ctrl.size;
      sign_ext_q  <= ctrl.sign_ext;
      trans_id_o  <= ctrl.trans_id;
      exception_o <= ctrl.ex_valid;
      cause_o     <= ctrl.ex_cause;
      result_o    <= '0;
    end else if (state_q == lsu_pkg::LD_WAIT_DATA && mem.rvalid) begin
      result_o    <= extended;
    end
  end

  assign valid_o = (state_q == lsu_pkg::LD_DONE);

endmodule

// ==== source/store_unit.sv ====
`timescale 1ns/1ps

module store_unit #(
  parameter int STORE_BUF_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   commit_i,
  input  lsu_pkg::page_offset_t  ld_page_offset_i,
  output logic                   offset_match_o,
  output logic                   commit_ready_o,
  output logic                   no_st_pending_o,
  output logic                   valid_o,
  output lsu_pkg::trans_id_t     trans_id_o,
  output logic                   exception_o,
  output lsu_pkg::exc_cause_t    cause_o,
  lsu_ctrl_if.st_sink            ctrl,
  mem_port_if.client             mem
);

  localparam int PW = (STORE_BUF_DEPTH > 1) ? $clog2(STORE_BUF_DEPTH) : 1;

  lsu_pkg::word_addr_t addr_q [STORE_BUF_DEPTH];
  lsu_pkg::xlen_t      data_q [STORE_BUF_DEPTH];
  lsu_pkg::be_t        be_q   [STORE_BUF_DEPTH];

  logic [STORE_BUF_DEPTH-1:0] sb_valid_q, sb_commit_q;
  logic [PW-1:0]              wr_ptr_q, commit_ptr_q, drain_ptr_q;
  logic                       pop, push, do_commit, drain;

  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(STORE_BUF_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // faulting stores never need a slot
  assign pop  = ctrl.valid && ctrl.is_store && (ctrl.ex_valid || !(&sb_valid_q));
  assign push = pop && !ctrl.ex_valid;
  assign ctrl.pop_st = pop;

  assign commit_ready_o  = sb_valid_q[commit_ptr_q] && !sb_commit_q[commit_ptr_q];
  assign do_commit       = commit_i && commit_ready_o;
  assign no_st_pending_o = !(|sb_valid_q);

  // ==============================
  // drain port
  // ==============================
  assign mem.req   = sb_valid_q[drain_ptr_q] && sb_commit_q[drain_ptr_q];
  assign mem.we    = 1'b1;
  assign mem.addr  = addr_q[drain_ptr_q];
  assign mem.wdata = data_q[drain_ptr_q];
  assign mem.be    = be_q[drain_ptr_q];
  assign drain     = mem.req && mem.gnt;

  // dword match against every live entry, committed or not
  always_comb begin
    offset_match_o = 1'b0;
    for (int i = 0; i < STORE_BUF_DEPTH; i++) begin
      if (sb_valid_q[i] &&
          addr_q[i] == ld_page_offset_i[lsu_pkg::PAGE_OFFSET_W-1:lsu_pkg::BYTE_SEL_W])
        offset_match_o = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sb_valid_q   <= '0;
      sb_commit_q  <= '0;
      wr_ptr_q     <= '0;
      commit_ptr_q <= '0;
      drain_ptr_q  <= '0;
      valid_o      <= 1'b0;
    end else begin
      valid_o <= pop;  // report one cycle after the pop
      if (push) begin
        sb_valid_q[wr_ptr_q]  <= 1'b1;
        sb_commit_q[wr_ptr_q] <= 1'b0;
        wr_ptr_q              <= ptr_inc(wr_ptr_q);
      end
      if (do_commit) begin
        sb_commit_q[commit_ptr_q] <= 1'b1;
        commit_ptr_q              <= ptr_inc(commit_ptr_q);
      end
      if (drain) begin
        sb_valid_q[drain_ptr_q]  <= 1'b0;
        sb_commit_q[drain_ptr_q] <= 1'b0;
        drain_ptr_q              <= ptr_inc(drain_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_q[wr_ptr_q] <= ctrl.vaddr[lsu_pkg::PAGE_OFFSET_W-1:lsu_pkg::BYTE_SEL_W];
      data_q[wr_ptr_q] <= ctrl.wdata;
      be_q[wr_ptr_q]   <= ctrl.be;
    end
    if (pop) begin
      trans_id_o  <= ctrl.trans_id;
      exception_o <= ctrl.ex_valid;
      cause_o     <= ctrl.ex_cause;
    end
  end

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic       clk_i,
  input  logic       reset_i,
  mem_port_if.server ld_port,
  mem_port_if.server st_port,
  mem_port_if.client ram_port
);

  logic ld_sel;
  logic rd_owner_ld_q;  // who gets the next rvalid

  assign ld_sel = ld_port.req;  // load always wins

  assign ram_port.req   = ld_port.req || st_port.req;
  assign ram_port.we    = ld_sel ? ld_port.we    : st_port.we;
  assign ram_port.addr  = ld_sel ? ld_port.addr  : st_port.addr;
  assign ram_port.wdata = ld_sel ? ld_port.wdata : st_port.wdata;
  assign ram_port.be    = ld_sel ? ld_port.be    : st_port.be;

  assign ld_port.gnt = ld_sel && ram_port.gnt;
  assign st_port.gnt = !ld_sel && st_port.req && ram_port.gnt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_owner_ld_q <= 1'b0;
    end else if (ram_port.req && ram_port.gnt && !ram_port.we) begin
      rd_owner_ld_q <= ld_sel;
    end
  end

  // ==============================
  // response routing
  // ==============================
  assign ld_port.rvalid = ram_port.rvalid && rd_owner_ld_q;
  assign st_port.rvalid = ram_port.rvalid && !rd_owner_ld_q;
  assign ld_port.rdata  = rd_owner_ld_q ? ram_port.rdata : '0;
  assign st_port.rdata  = rd_owner_ld_q ? '0 : ram_port.rdata;

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS = 512
) (
  input  logic       clk_i,
  mem_port_if.server port
);

  localparam int AW = $clog2(RAM_WORDS);

  lsu_pkg::xlen_t mem [RAM_WORDS];

  assign port.gnt = port.req;  // single client after arbitration, never busy

  always_ff @(posedge clk_i) begin
    port.rvalid <= port.req && !port.we;
    if (port.req && port.we) begin
      for (int b = 0; b < lsu_pkg::BE_W; b++) begin
        if (port.be[b]) mem[port.addr[AW-1:0]][b*8 +: 8] <= port.wdata[b*8 +: 8];
      end
    end else if (port.req) begin
      port.rdata <= mem[port.addr[AW-1:0]];
    end
  end

endmodule

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
  parameter int QUEUE_DEPTH     = 2,
  parameter int STORE_BUF_DEPTH = 4,
  parameter int RAM_WORDS       = 512
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                lsu_valid_i,
  input  logic                is_store_i,
  input  lsu_pkg::mem_size_t  size_i,
  input  logic                sign_ext_i,
  input  lsu_pkg::xlen_t      operand_a_i,
  input  lsu_pkg::xlen_t      imm_i,
  input  lsu_pkg::xlen_t      store_data_i,
  input  lsu_pkg::trans_id_t  trans_id_i,
  input  logic                commit_i,
  output logic                lsu_ready_o,
  output logic                load_valid_o,
  output lsu_pkg::trans_id_t  load_trans_id_o,
  output lsu_pkg::xlen_t      load_result_o,
  output logic                load_exception_o,
  output lsu_pkg::exc_cause_t load_cause_o,
  output logic                store_valid_o,
  output lsu_pkg::trans_id_t  store_trans_id_o,
  output logic                store_exception_o,
  output lsu_pkg::exc_cause_t store_cause_o,
  output logic                commit_ready_o,
  output logic                no_st_pending_o
);

  lsu_pkg::xlen_t         vaddr, wdata;
  lsu_pkg::be_t           be;
  logic                   ex_valid, offset_match;
  lsu_pkg::exc_cause_t    ex_cause;
  lsu_pkg::page_offset_t  ld_page_offset;

  lsu_ctrl_if ctrl_if ();
  mem_port_if ld_mem  ();
  mem_port_if st_mem  ();
  mem_port_if ram_mem ();

  // ==============================
  // request side
  // ==============================
  lsu_addr_check addr_check_i (
    .is_store_i   (is_store_i),
    .size_i       (size_i),
    .operand_a_i  (operand_a_i),
    .imm_i        (imm_i),
    .store_data_i (store_data_i),
    .vaddr_o      (vaddr),
    .be_o         (be),
    .wdata_o      (wdata),
    .ex_valid_o   (ex_valid),
    .ex_cause_o   (ex_cause)
  );

  lsu_bypass #(.QUEUE_DEPTH(QUEUE_DEPTH)) bypass_i (
    .clk_i, .reset_i,
    .valid_i    (lsu_valid_i),
    .is_store_i (is_store_i),
    .size_i     (size_i),
    .sign_ext_i (sign_ext_i),
    .vaddr_i    (vaddr),
    .wdata_i    (wdata),
    .be_i       (be),
    .trans_id_i (trans_id_i),
    .ex_valid_i (ex_valid),
    .ex_cause_i (ex_cause),
    .ready_o    (lsu_ready_o),
    .ctrl       (ctrl_if.source)
  );

  // ==============================
  // execution units
  // ==============================
  load_unit load_unit_i (
    .clk_i, .reset_i,
    .offset_match_i   (offset_match),
    .ld_page_offset_o (ld_page_offset),
    .valid_o          (load_valid_o),
    .trans_id_o       (load_trans_id_o),
    .result_o         (load_result_o),
    .exception_o      (load_exception_o),
    .cause_o          (load_cause_o),
    .ctrl             (ctrl_if.ld_sink),
    .mem              (ld_mem.client)
  );

  store_unit #(.STORE_BUF_DEPTH(STORE_BUF_DEPTH)) store_unit_i (
    .clk_i, .reset_i,
    .commit_i         (commit_i),
    .ld_page_offset_i (ld_page_offset),
    .offset_match_o   (offset_match),
    .commit_ready_o   (commit_ready_o),
    .no_st_pending_o  (no_st_pending_o),
    .valid_o          (store_valid_o),
    .trans_id_o       (store_trans_id_o),
    .exception_o      (store_exception_o),
    .cause_o          (store_cause_o),
    .ctrl             (ctrl_if.st_sink),
    .mem              (st_mem.client)
  );

  mem_arbiter arbiter_i (
    .clk_i, .reset_i,
    .ld_port  (ld_mem.server),
    .st_port  (st_mem.server),
    .ram_port (ram_mem.client)
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) ram_i (
    .clk_i,
    .port (ram_mem.server)
  );

endmodule

// ==== verif/lsu_tb.sv ====
`timescale 1ns/1ps

module lsu_tb;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_OPS      = 300;
  localparam int WINDOW_WORDS = 16;
  localparam int BP_STORES    = 6;  // store buffer plus request queue
  localparam int DRAIN_CYCLES = 200;  // commit and write back of a full buffer
  localparam int WATCHDOG_CYCLES =
    (NUM_OPS + 2 * WINDOW_WORDS + BP_STORES) * 60 + RESET_CYCLES;
  localparam logic [63:0] WIN_BASE = 64'h0000_0000_8000_0100;
  localparam logic [63:0] OVF_BASE = 64'h0000_0040_0000_0100;  // bit 38 alone set

  typedef struct packed {
    logic [2:0]  tag;
    logic        exc;
    logic [3:0]  cause;
    logic [63:0] value;
  } resp_t;

  logic clk_i, reset_i, lsu_valid_i, is_store_i, sign_ext_i, commit_i;
  lsu_pkg::mem_size_t  size_i;
  logic [63:0]         operand_a_i, imm_i, store_data_i;
  logic [2:0]          trans_id_i;
  logic                lsu_ready_o, load_valid_o, load_exception_o;
  logic                store_valid_o, store_exception_o, commit_ready_o, no_st_pending_o;
  logic [2:0]          load_trans_id_o, store_trans_id_o;
  logic [63:0]         load_result_o;
  logic [3:0]          load_cause_o, store_cause_o;

  logic [63:0] model_mem [WINDOW_WORDS];
  resp_t       ld_exp [$];
  resp_t       st_exp [$];
  logic [2:0]  next_tag = '0;
  logic        commit_en = 1'b0;
  logic        commit_seen = 1'b0;
  int          checks = 0;
  int          errors = 0;

  lsu_top dut_i (
    .clk_i, .reset_i, .lsu_valid_i, .is_store_i, .size_i, .sign_ext_i, .operand_a_i,
    .imm_i, .store_data_i, .trans_id_i, .commit_i, .lsu_ready_o, .load_valid_o,
    .load_trans_id_o, .load_result_o, .load_exception_o, .load_cause_o, .store_valid_o,
    .store_trans_id_o, .store_exception_o, .store_cause_o, .commit_ready_o,
    .no_st_pending_o
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // ==============================
  // reference model helpers
  // ==============================
  function automatic logic [2:0] low_mask(input logic [1:0] size);
    return 3'((1 << size) - 1);  // address bits that must be zero
  endfunction

  function automatic logic [63:0] load_value(input logic [63:0] word, input logic [2:0] lane,
                                             input logic [1:0] size, input logic sext);
    logic [63:0] v;
    logic [7:0]  fill;
    int          nbytes;
    nbytes = 1 << size;
    v = '0;
    for (int b = 0; b < nbytes; b++) v[b*8 +: 8] = word[(lane + b)*8 +: 8];
    fill = (sext && v[nbytes*8-1]) ? 8'hff : 8'h00;
    for (int b = nbytes; b < 8; b++) v[b*8 +: 8] = fill;
    return v;
  endfunction

  function automatic logic [63:0] store_merge(input logic [63:0] word, input logic [2:0] lane,
                                              input logic [1:0] size, input logic [63:0] data);
    logic [63:0] w;
    w = word;
    for (int b = 0; b < (1 << size); b++) w[(lane + b)*8 +: 8] = data[b*8 +: 8];
    return w;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ==============================
  // stimulus
  // ==============================
  task automatic issue_op(input logic st, input logic [1:0] size, input logic sext,
                          input logic [63:0] opa, input logic [63:0] imm,
                          input logic [63:0] data, input int word);
    logic [63:0] addr;
    logic        ovf, mis;
    resp_t       r;
    @(posedge clk_i);
    lsu_valid_i  <= 1'b1;
    is_store_i   <= st;
    size_i       <= lsu_pkg::mem_size_t'(size);
    sign_ext_i   <= sext;
    operand_a_i  <= opa;
    imm_i        <= imm;
    store_data_i <= data;
    trans_id_i   <= next_tag;
    @(negedge clk_i);
    while (!lsu_ready_o) @(negedge clk_i);
    // accepted at the coming edge, so update the model now
    addr    = opa + imm;
    ovf     = !(addr[63:38] == {26{1'b0}} || addr[63:38] == {26{1'b1}});
    mis     = (addr[2:0] & low_mask(size)) != 3'b000;
    r.tag   = next_tag;
    r.exc   = ovf || mis;
    r.cause = ovf ? (st ? 4'd15 : 4'd13) : (st ? 4'd6 : 4'd4);
    r.value = '0;
    if (st) begin
      if (!r.exc) model_mem[word] = store_merge(model_mem[word], addr[2:0], size, data);
      st_exp.push_back(r);
    end else begin
      if (!r.exc) r.value = load_value(model_mem[word], addr[2:0], size, sext);
      ld_exp.push_back(r);
    end
    next_tag = next_tag + 3'd1;
  endtask

  task automatic random_op();
    logic       st, sext, mis, ovf;
    logic [1:0] size;
    logic [2:0] lane;
    int         word;
    st   = 1'($urandom_range(0, 1));
    size = 2'($urandom_range(0, 3));
    sext = 1'($urandom_range(0, 1));
    word = $urandom_range(0, WINDOW_WORDS - 1);
    mis  = ($urandom_range(0, 9) == 0);
    ovf  = ($urandom_range(0, 11) == 0);
    lane = 3'($urandom_range(0, 7));
    if (!mis) lane = lane & ~low_mask(size);  // round down to the access size
    issue_op(st, size, sext, ovf ? OVF_BASE : WIN_BASE, 64'(word * 8 + lane),
             {$urandom, $urandom}, word);
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    lsu_valid_i <= 1'b0;
  endtask

  task automatic wait_drained();
    @(negedge clk_i);
    while (ld_exp.size() != 0 || st_exp.size() != 0) @(negedge clk_i);
    // buffered stores still need commit and write back
    for (int i = 0; i < DRAIN_CYCLES && !no_st_pending_o; i++) @(negedge clk_i);
  endtask

  // commits at random while the DUT has something to commit
  always @(negedge clk_i) commit_seen <= commit_ready_o;

  always @(posedge clk_i) begin
    if (reset_i) commit_i <= 1'b0;
    else commit_i <= commit_en && commit_seen && ($urandom_range(0, 3) == 0);
  end

  // ==============================
  // response checking
  // ==============================
  always @(negedge clk_i) begin : response_monitor
    resp_t r;
    if (!reset_i && load_valid_o) begin
      if (ld_exp.size() == 0) begin
        errors++;
        $display("load response at %0t ns with no load outstanding", $time);
      end else begin
        r = ld_exp.pop_front();
        check_value("load_trans_id_o", 64'(load_trans_id_o), 64'(r.tag));
        check_value("load_exception_o", 64'(load_exception_o), 64'(r.exc));
        if (r.exc) check_value("load_cause_o", 64'(load_cause_o), 64'(r.cause));
        else       check_value("load_result_o", load_result_o, r.value);
      end
    end
    if (!reset_i && store_valid_o) begin
      if (st_exp.size() == 0) begin
        errors++;
        $display("store response at %0t ns with no store outstanding", $time);
      end else begin
        r = st_exp.pop_front();
        check_value("store_trans_id_o", 64'(store_trans_id_o), 64'(r.tag));
        check_value("store_exception_o", 64'(store_exception_o), 64'(r.exc));
        if (r.exc) check_value("store_cause_o", 64'(store_cause_o), 64'(r.cause));
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'h2d09_3ee8));
    reset_i      = 1'b1;
    lsu_valid_i  = 1'b0;
    is_store_i   = 1'b0;
    size_i       = lsu_pkg::SIZE_B;
    sign_ext_i   = 1'b0;
    operand_a_i  = '0;
    imm_i        = '0;
    store_data_i = '0;
    trans_id_i   = '0;
    commit_i     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("load_valid_o", 64'(load_valid_o), 64'd0);
    check_value("store_valid_o", 64'(store_valid_o), 64'd0);
    check_value("commit_ready_o", 64'(commit_ready_o), 64'd0);
    check_value("lsu_ready_o", 64'(lsu_ready_o), 64'd1);
    check_value("no_st_pending_o", 64'(no_st_pending_o), 64'd1);

    commit_en = 1'b1;
    for (int w = 0; w < WINDOW_WORDS; w++)
      issue_op(1'b1, 2'd3, 1'b0, WIN_BASE, 64'(w * 8), {$urandom, $urandom}, w);
    go_idle();
    wait_drained();

    // withhold commits until the queue backs up
    commit_en = 1'b0;
    for (int i = 0; i < BP_STORES; i++)
      issue_op(1'b1, 2'd3, 1'b0, WIN_BASE, 64'(i * 8), {$urandom, $urandom}, i);
    go_idle();
    for (int i = 0; i < 12 && lsu_ready_o; i++) @(negedge clk_i);
    check_value("lsu_ready_o", 64'(lsu_ready_o), 64'd0);
    repeat (20) @(negedge clk_i);
    check_value("no_st_pending_o", 64'(no_st_pending_o), 64'd0);
    commit_en = 1'b1;

    // page fault wins over misalignment
    issue_op(1'b0, 2'd3, 1'b1, OVF_BASE, 64'd5, '0, 0);
    issue_op(1'b1, 2'd2, 1'b0, OVF_BASE, 64'd2, {$urandom, $urandom}, 0);

    for (int n = 0; n < NUM_OPS; n++) begin
      random_op();
      if ($urandom_range(0, 7) == 0) go_idle();
    end
    for (int w = 0; w < WINDOW_WORDS; w++)
      issue_op(1'b0, 2'd3, 1'b0, WIN_BASE, 64'(w * 8), '0, w);  // final readback
    go_idle();
    wait_drained();
    check_value("no_st_pending_o", 64'(no_st_pending_o), 64'd1);
    check_value("lsu_ready_o", 64'(lsu_ready_o), 64'd1);
    check_value("commit_ready_o", 64'(commit_ready_o), 64'd0);

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== lsu_top.f ====
source/lsu_pkg.sv
source/mem_port_if.sv
source/lsu_ctrl_if.sv
source/lsu_addr_check.sv
source/lsu_bypass.sv
source/load_unit.sv
source/store_unit.sv
source/mem_arbiter.sv
source/data_ram.sv
source/lsu_top.sv
verif/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the LSU testbench with Verilator, run it and scan the log for the result.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f lsu_top.f --top-module lsu_tb -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
